//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= bru_iq_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hdl/bru_iq_pkg.sv
hdl/bru_iq_ifs.sv
hdl/bru_iq_entry_store.sv
hdl/bru_iq_wakeup.sv
hdl/bru_iq_select.sv
hdl/bru_iq_top.sv
verification/bru_iq_checker.sv
verification/bru_iq_tb.sv

//--- hdl/bru_iq_entry_store.sv
`timescale 1ns/1ps

module bru_iq_entry_store import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	// enqueue
	input logic iq_enq_valid,
	input br_op_t iq_enq_op,
	input pc_t iq_enq_PC,
	input imm20_t iq_enq_imm20,
	input pr_t iq_enq_A_PR,
	input pr_t iq_enq_B_PR,
	input pr_t iq_enq_dest_PR,
	input logic iq_enq_A_ready,
	input logic iq_enq_A_unneeded_or_is_zero,
	input logic iq_enq_B_ready,
	input logic iq_enq_B_unneeded_or_is_zero,
	input rob_idx_t iq_enq_ROB_index,
	output logic iq_enq_ready,

	// from select
	input logic [IQ_ENTRIES-1:0] issue_grant,

	iq_alloc_if.source alloc,
	iq_entry_if.source entries
);

	logic [IQ_ENTRIES-1:0] valid_q;
	logic [IQ_ENTRIES-1:0][IQ_ENTRIES-1:0] age_q;
	logic [IQ_ENTRIES-1:0] free_onehot;
	logic [IQ_ENTRIES-1:0] alloc_vec;

	br_op_t [IQ_ENTRIES-1:0] op_q;
	pc_t [IQ_ENTRIES-1:0] pc_q;
	imm20_t [IQ_ENTRIES-1:0] imm20_q;
	pr_t [IQ_ENTRIES-1:0] dest_pr_q;
	rob_idx_t [IQ_ENTRIES-1:0] rob_index_q;
	logic [IQ_ENTRIES-1:0] a_unneeded_q;
	logic [IQ_ENTRIES-1:0] b_unneeded_q;

	// --------------------
	// allocation

	// lowest-numbered free slot wins
	always_comb begin
		free_onehot = '0;
		for (int i = IQ_ENTRIES - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_onehot = '0;
				free_onehot[i] = 1'b1;
			end
		end
	end

	assign iq_enq_ready = ~&valid_q;
	assign alloc_vec = (iq_enq_valid && iq_enq_ready) ? free_onehot : '0;

	// sources handed to wakeup with unneeded folded in
	assign alloc.alloc = alloc_vec;
	assign alloc.a_pr = iq_enq_A_PR;
	assign alloc.b_pr = iq_enq_B_PR;
	assign alloc.a_ready = iq_enq_A_ready | iq_enq_A_unneeded_or_is_zero;
	assign alloc.b_ready = iq_enq_B_ready | iq_enq_B_unneeded_or_is_zero;

	// --------------------
	// valid bits and age order

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			age_q <= '0;
		end else begin
			// granted slot is never the one just allocated
			valid_q <= (valid_q & ~issue_grant) | alloc_vec;
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				if (alloc_vec[i]) begin
					// new op is younger than everyone
					age_q[i] <= '0;
				end else begin
					age_q[i] <= age_q[i] | alloc_vec;
				end
			end
		end
	end

	// payload
	always_ff @(posedge CLK) begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (alloc_vec[i]) begin
				op_q[i] <= iq_enq_op;
				pc_q[i] <= iq_enq_PC;
				imm20_q[i] <= iq_enq_imm20;
				dest_pr_q[i] <= iq_enq_dest_PR;
				rob_index_q[i] <= iq_enq_ROB_index;
				a_unneeded_q[i] <= iq_enq_A_unneeded_or_is_zero;
				b_unneeded_q[i] <= iq_enq_B_unneeded_or_is_zero;
			end
		end
	end

	assign entries.valid = valid_q;
	assign entries.age = age_q;
	assign entries.op = op_q;
	assign entries.pc = pc_q;
	assign entries.imm20 = imm20_q;
	assign entries.dest_pr = dest_pr_q;
	assign entries.rob_index = rob_index_q;
	assign entries.a_unneeded = a_unneeded_q;
	assign entries.b_unneeded = b_unneeded_q;

endmodule

//--- hdl/bru_iq_ifs.sv
`timescale 1ns/1ps

// --------------------
// new op sources, entry store to wakeup

interface iq_alloc_if import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) ();

	// one-hot slot being written this edge
	logic [IQ_ENTRIES-1:0] alloc;
	pr_t a_pr;
	pr_t b_pr;
	// already folded with unneeded-or-zero
	logic a_ready;
	logic b_ready;

	modport source (output alloc, a_pr, b_pr, a_ready, b_ready);
	modport sink (input alloc, a_pr, b_pr, a_ready, b_ready);

endinterface

// --------------------
// per-slot readiness, wakeup to select

interface iq_ready_if import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) ();

	logic [IQ_ENTRIES-1:0] ready_a;
	logic [IQ_ENTRIES-1:0] ready_b;
	// same-cycle writeback hit
	logic [IQ_ENTRIES-1:0] wake_a;
	logic [IQ_ENTRIES-1:0] wake_b;
	pr_t [IQ_ENTRIES-1:0] a_pr;
	pr_t [IQ_ENTRIES-1:0] b_pr;

	modport source (output ready_a, ready_b, wake_a, wake_b, a_pr, b_pr);
	modport sink (input ready_a, ready_b, wake_a, wake_b, a_pr, b_pr);

endinterface

// --------------------
// slot state and payload, entry store to select

interface iq_entry_if import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) ();

	logic [IQ_ENTRIES-1:0] valid;
	// age[i][j] set: slot i older than slot j
	logic [IQ_ENTRIES-1:0][IQ_ENTRIES-1:0] age;
	br_op_t [IQ_ENTRIES-1:0] op;
	pc_t [IQ_ENTRIES-1:0] pc;
	imm20_t [IQ_ENTRIES-1:0] imm20;
	pr_t [IQ_ENTRIES-1:0] dest_pr;
	rob_idx_t [IQ_ENTRIES-1:0] rob_index;
	logic [IQ_ENTRIES-1:0] a_unneeded;
	logic [IQ_ENTRIES-1:0] b_unneeded;

	modport source (output valid, age, op, pc, imm20, dest_pr, rob_index,
		a_unneeded, b_unneeded);
	modport sink (input valid, age, op, pc, imm20, dest_pr, rob_index,
		a_unneeded, b_unneeded);

endinterface

//--- hdl/bru_iq_pkg.sv
package bru_iq_pkg;

	// --------------------
	// core widths

	parameter int LOG_PR_COUNT = 6;
	parameter int LOG_ROB_ENTRIES = 5;

	// writeback and register file banking
	parameter int LOG_PRF_BANK_COUNT = 2;
	parameter int PRF_BANK_COUNT = 4;

	// --------------------
	// field types

	typedef logic [LOG_PR_COUNT-1:0] pr_t;

	// tag carried on a writeback bus, bank bits stripped off
	typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;

	// low bits of a pr_t
	typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;

	typedef logic [LOG_ROB_ENTRIES-1:0] rob_idx_t;
	typedef logic [31:0] pc_t;
	typedef logic [19:0] imm20_t;
	typedef logic [3:0] br_op_t;

endpackage

//--- hdl/bru_iq_select.sv
`timescale 1ns/1ps

module bru_iq_select import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	iq_entry_if.sink entries,
	iq_ready_if.sink ready,

	// pipeline feedback
	input logic issue_ready,

	output logic [IQ_ENTRIES-1:0] issue_grant,

	// pipeline issue
	output logic issue_valid,
	output br_op_t issue_op,
	output pc_t issue_PC,
	output imm20_t issue_imm20,
	output logic issue_A_forward,
	output logic issue_A_unneeded_or_is_zero,
	output bank_t issue_A_bank,
	output logic issue_B_forward,
	output logic issue_B_unneeded_or_is_zero,
	output bank_t issue_B_bank,
	output pr_t issue_dest_PR,
	output rob_idx_t issue_ROB_index,

	// register file read requests
	output logic PRF_req_A_valid,
	output pr_t PRF_req_A_PR,
	output logic PRF_req_B_valid,
	output pr_t PRF_req_B_PR
);

	localparam int IDX_W = $clog2(IQ_ENTRIES);

	logic [IQ_ENTRIES-1:0] cand;
	logic [IQ_ENTRIES-1:0] oldest;
	logic [IDX_W-1:0] sel_idx;
	logic any_grant;
	logic fwd_a;
	logic fwd_b;

	// --------------------
	// oldest ready pick

	assign cand = entries.valid
		& (ready.ready_a | ready.wake_a)
		& (ready.ready_b | ready.wake_b);

	// drop any candidate that some other candidate is older than
	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			oldest[i] = cand[i];
			for (int j = 0; j < IQ_ENTRIES; j++) begin
				if (j != i && cand[j] && entries.age[j][i]) begin
					oldest[i] = 1'b0;
				end
			end
		end
	end

	assign issue_grant = issue_ready ? oldest : '0;
	assign any_grant = |issue_grant;

	// index of the one-hot winner
	always_comb begin
		sel_idx = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (oldest[i]) begin
				sel_idx = IDX_W'(i);
			end
		end
	end

	// woke this cycle, not yet latched as ready
	assign fwd_a = ready.wake_a[sel_idx] & ~ready.ready_a[sel_idx];
	assign fwd_b = ready.wake_b[sel_idx] & ~ready.ready_b[sel_idx];

	// --------------------
	// issue registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
			PRF_req_A_valid <= 1'b0;
			PRF_req_B_valid <= 1'b0;
		end else begin
			issue_valid <= any_grant;
			PRF_req_A_valid <= any_grant & ~fwd_a & ~entries.a_unneeded[sel_idx];
			PRF_req_B_valid <= any_grant & ~fwd_b & ~entries.b_unneeded[sel_idx];
		end
	end

	always_ff @(posedge CLK) begin
		if (any_grant) begin
			issue_op <= entries.op[sel_idx];
			issue_PC <= entries.pc[sel_idx];
			issue_imm20 <= entries.imm20[sel_idx];
			issue_A_forward <= fwd_a;
			issue_A_unneeded_or_is_zero <= entries.a_unneeded[sel_idx];
			issue_A_bank <= ready.a_pr[sel_idx][LOG_PRF_BANK_COUNT-1:0];
			issue_B_forward <= fwd_b;
			issue_B_unneeded_or_is_zero <= entries.b_unneeded[sel_idx];
			issue_B_bank <= ready.b_pr[sel_idx][LOG_PRF_BANK_COUNT-1:0];
			issue_dest_PR <= entries.dest_pr[sel_idx];
			issue_ROB_index <= entries.rob_index[sel_idx];
			PRF_req_A_PR <= ready.a_pr[sel_idx];
			PRF_req_B_PR <= ready.b_pr[sel_idx];
		end
	end

endmodule

//--- hdl/bru_iq_top.sv
`timescale 1ns/1ps

module bru_iq_top import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	// op enqueue
	input logic iq_enq_valid,
	input br_op_t iq_enq_op,
	input pc_t iq_enq_PC,
	input imm20_t iq_enq_imm20,
	input pr_t iq_enq_A_PR,
	input logic iq_enq_A_ready,
	input logic iq_enq_A_unneeded_or_is_zero,
	input pr_t iq_enq_B_PR,
	input logic iq_enq_B_ready,
	input logic iq_enq_B_unneeded_or_is_zero,
	input pr_t iq_enq_dest_PR,
	input rob_idx_t iq_enq_ROB_index,
	output logic iq_enq_ready,

	// writeback bus by bank
	input logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	// pipeline issue
	output logic issue_valid,
	output br_op_t issue_op,
	output pc_t issue_PC,
	output imm20_t issue_imm20,
	output logic issue_A_forward,
	output logic issue_A_unneeded_or_is_zero,
	output bank_t issue_A_bank,
	output logic issue_B_forward,
	output logic issue_B_unneeded_or_is_zero,
	output bank_t issue_B_bank,
	output pr_t issue_dest_PR,
	output rob_idx_t issue_ROB_index,
	input logic issue_ready,

	// register file read requests
	output logic PRF_req_A_valid,
	output pr_t PRF_req_A_PR,
	output logic PRF_req_B_valid,
	output pr_t PRF_req_B_PR
);

	logic [IQ_ENTRIES-1:0] issue_grant;

	iq_alloc_if #(.IQ_ENTRIES(IQ_ENTRIES)) u_alloc_if ();
	iq_ready_if #(.IQ_ENTRIES(IQ_ENTRIES)) u_ready_if ();
	iq_entry_if #(.IQ_ENTRIES(IQ_ENTRIES)) u_entry_if ();

	// payload and age order
	bru_iq_entry_store #(.IQ_ENTRIES(IQ_ENTRIES)) u_entry_store (
		.CLK(CLK),
		.nRST(nRST),
		.iq_enq_valid(iq_enq_valid),
		.iq_enq_op(iq_enq_op),
		.iq_enq_PC(iq_enq_PC),
		.iq_enq_imm20(iq_enq_imm20),
		.iq_enq_A_PR(iq_enq_A_PR),
		.iq_enq_B_PR(iq_enq_B_PR),
		.iq_enq_dest_PR(iq_enq_dest_PR),
		.iq_enq_A_ready(iq_enq_A_ready),
		.iq_enq_A_unneeded_or_is_zero(iq_enq_A_unneeded_or_is_zero),
		.iq_enq_B_ready(iq_enq_B_ready),
		.iq_enq_B_unneeded_or_is_zero(iq_enq_B_unneeded_or_is_zero),
		.iq_enq_ROB_index(iq_enq_ROB_index),
		.iq_enq_ready(iq_enq_ready),
		.issue_grant(issue_grant),
		.alloc(u_alloc_if.source),
		.entries(u_entry_if.source)
	);

	// operand readiness
	bru_iq_wakeup #(.IQ_ENTRIES(IQ_ENTRIES)) u_wakeup (
		.CLK(CLK),
		.nRST(nRST),
		.alloc(u_alloc_if.sink),
		.WB_bus_valid_by_bank(WB_bus_valid_by_bank),
		.WB_bus_upper_PR_by_bank(WB_bus_upper_PR_by_bank),
		.issue_grant(issue_grant),
		.ready(u_ready_if.source)
	);

	bru_iq_select #(.IQ_ENTRIES(IQ_ENTRIES)) u_select (
		.CLK(CLK),
		.nRST(nRST),
		.entries(u_entry_if.sink),
		.ready(u_ready_if.sink),
		.issue_ready(issue_ready),
		.issue_grant(issue_grant),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_PC(issue_PC),
		.issue_imm20(issue_imm20),
		.issue_A_forward(issue_A_forward),
		.issue_A_unneeded_or_is_zero(issue_A_unneeded_or_is_zero),
		.issue_A_bank(issue_A_bank),
		.issue_B_forward(issue_B_forward),
		.issue_B_unneeded_or_is_zero(issue_B_unneeded_or_is_zero),
		.issue_B_bank(issue_B_bank),
		.issue_dest_PR(issue_dest_PR),
		.issue_ROB_index(issue_ROB_index),
		.PRF_req_A_valid(PRF_req_A_valid),
		.PRF_req_A_PR(PRF_req_A_PR),
		.PRF_req_B_valid(PRF_req_B_valid),
		.PRF_req_B_PR(PRF_req_B_PR)
	);

endmodule

//--- hdl/bru_iq_wakeup.sv
`timescale 1ns/1ps

module bru_iq_wakeup import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	iq_alloc_if.sink alloc,

	// writeback bus by bank
	input logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	input logic [IQ_ENTRIES-1:0] issue_grant,

	iq_ready_if.source ready
);

	pr_t [IQ_ENTRIES-1:0] a_pr_q;
	pr_t [IQ_ENTRIES-1:0] b_pr_q;
	logic [IQ_ENTRIES-1:0] ready_a_q;
	logic [IQ_ENTRIES-1:0] ready_b_q;
	logic [IQ_ENTRIES-1:0] wake_a;
	logic [IQ_ENTRIES-1:0] wake_b;
	logic alloc_wake_a;
	logic alloc_wake_b;

	// bank select in the low bits and the bus tag in the rest
	function automatic logic wb_hit(input pr_t pr);
		bank_t bank;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return WB_bus_valid_by_bank[bank]
			&& (WB_bus_upper_PR_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

	// --------------------
	// tag compare

	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			wake_a[i] = wb_hit(a_pr_q[i]);
			wake_b[i] = wb_hit(b_pr_q[i]);
		end
		// catch a writeback landing in the enqueue cycle too
		alloc_wake_a = wb_hit(alloc.a_pr);
		alloc_wake_b = wb_hit(alloc.b_pr);
	end

	// --------------------
	// ready bits

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ready_a_q <= '0;
			ready_b_q <= '0;
		end else begin
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				if (alloc.alloc[i]) begin
					ready_a_q[i] <= alloc.a_ready | alloc_wake_a;
					ready_b_q[i] <= alloc.b_ready | alloc_wake_b;
				end else if (issue_grant[i]) begin
					ready_a_q[i] <= 1'b0;
					ready_b_q[i] <= 1'b0;
				end else begin
					ready_a_q[i] <= ready_a_q[i] | wake_a[i];
					ready_b_q[i] <= ready_b_q[i] | wake_b[i];
				end
			end
		end
	end

	// source register numbers
	always_ff @(posedge CLK) begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (alloc.alloc[i]) begin
				a_pr_q[i] <= alloc.a_pr;
				b_pr_q[i] <= alloc.b_pr;
			end
		end
	end

	assign ready.ready_a = ready_a_q;
	assign ready.ready_b = ready_b_q;
	assign ready.wake_a = wake_a;
	assign ready.wake_b = wake_b;
	assign ready.a_pr = a_pr_q;
	assign ready.b_pr = b_pr_q;

endmodule

//--- verification/bru_iq_checker.sv
`timescale 1ns/1ps

module bru_iq_checker import bru_iq_pkg::*; #(
	parameter int IQ_ENTRIES = 8
) (
	input logic CLK,
	input logic nRST,

	// enqueue side
	input logic iq_enq_valid,
	input br_op_t iq_enq_op,
	input pc_t iq_enq_PC,
	input imm20_t iq_enq_imm20,
	input pr_t iq_enq_A_PR,
	input logic iq_enq_A_ready,
	input logic iq_enq_A_unneeded_or_is_zero,
	input pr_t iq_enq_B_PR,
	input logic iq_enq_B_ready,
	input logic iq_enq_B_unneeded_or_is_zero,
	input pr_t iq_enq_dest_PR,
	input rob_idx_t iq_enq_ROB_index,
	input logic iq_enq_ready,

	input logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank,
	input upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank,

	// issue side
	input logic issue_ready,
	input logic issue_valid,
	input br_op_t issue_op,
	input pc_t issue_PC,
	input imm20_t issue_imm20,
	input logic issue_A_forward,
	input logic issue_A_unneeded_or_is_zero,
	input bank_t issue_A_bank,
	input logic issue_B_forward,
	input logic issue_B_unneeded_or_is_zero,
	input bank_t issue_B_bank,
	input pr_t issue_dest_PR,
	input rob_idx_t issue_ROB_index,
	input logic PRF_req_A_valid,
	input pr_t PRF_req_A_PR,
	input logic PRF_req_B_valid,
	input pr_t PRF_req_B_PR
);

	typedef struct {
		logic valid;
		int unsigned seq;
		logic rdy_a;
		logic rdy_b;
		br_op_t op;
		pc_t pc;
		imm20_t imm20;
		pr_t a_pr;
		pr_t b_pr;
		logic a_un;
		logic b_un;
		pr_t dest;
		rob_idx_t rob;
	} slot_t;

	slot_t slots [IQ_ENTRIES];
	int unsigned next_seq = 0;

	// what the outputs must show after the current edge
	logic exp_valid = 1'b0;
	slot_t exp_slot;
	logic exp_fwd_a;
	logic exp_fwd_b;

	int mismatch_count = 0;
	int error_count = 0;
	int accepted_count = 0;
	int issued_count = 0;

	// each valid bus names the register built from its tag and its bank number
	function automatic logic woken(input pr_t pr);
		logic hit;
		hit = 1'b0;
		for (int bk = 0; bk < PRF_BANK_COUNT; bk++) begin
			if (WB_bus_valid_by_bank[bk]
				&& ({WB_bus_upper_PR_by_bank[bk], bank_t'(bk)} == pr)) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] act);
		if (expv !== act) begin
			mismatch_count++;
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expv, act);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("error: %s", msg);
	endtask

	// --------------------
	// issue outputs of the previous selection cycle

	task automatic check_issue();
		logic req_a;
		logic req_b;
		req_a = exp_valid && !exp_fwd_a && !exp_slot.a_un;
		req_b = exp_valid && !exp_fwd_b && !exp_slot.b_un;
		compare("issue_valid", 32'(exp_valid), 32'(issue_valid));
		compare("PRF_req_A_valid", 32'(req_a), 32'(PRF_req_A_valid));
		compare("PRF_req_B_valid", 32'(req_b), 32'(PRF_req_B_valid));
		if (exp_valid && issue_valid) begin
			issued_count++;
			compare("issue_op", 32'(exp_slot.op), 32'(issue_op));
			compare("issue_PC", exp_slot.pc, issue_PC);
			compare("issue_imm20", 32'(exp_slot.imm20), 32'(issue_imm20));
			compare("issue_dest_PR", 32'(exp_slot.dest), 32'(issue_dest_PR));
			compare("issue_ROB_index", 32'(exp_slot.rob), 32'(issue_ROB_index));
			compare("issue_A_forward", 32'(exp_fwd_a), 32'(issue_A_forward));
			compare("issue_B_forward", 32'(exp_fwd_b), 32'(issue_B_forward));
			compare("issue_A_unneeded", 32'(exp_slot.a_un), 32'(issue_A_unneeded_or_is_zero));
			compare("issue_B_unneeded", 32'(exp_slot.b_un), 32'(issue_B_unneeded_or_is_zero));
			compare("issue_A_bank", 32'(exp_slot.a_pr[LOG_PRF_BANK_COUNT-1:0]),
				32'(issue_A_bank));
			compare("issue_B_bank", 32'(exp_slot.b_pr[LOG_PRF_BANK_COUNT-1:0]),
				32'(issue_B_bank));
			if (req_a) begin
				compare("PRF_req_A_PR", 32'(exp_slot.a_pr), 32'(PRF_req_A_PR));
			end
			if (req_b) begin
				compare("PRF_req_B_PR", 32'(exp_slot.b_pr), 32'(PRF_req_B_PR));
			end
		end
	endtask

	// --------------------
	// model step at the falling edge where inputs and outputs are stable

	always @(negedge CLK) begin : model_step
		int sel;
		int free_idx;
		int cnt;
		logic wa;
		logic wb;
		if (!nRST) begin
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				slots[i].valid = 1'b0;
			end
			exp_valid = 1'b0;
			if (iq_enq_ready !== 1'b1 || issue_valid !== 1'b0
				|| PRF_req_A_valid !== 1'b0 || PRF_req_B_valid !== 1'b0) begin
				report_error("outputs not at their reset values during reset");
			end
		end else begin
			check_issue();

			cnt = 0;
			free_idx = -1;
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				if (slots[i].valid) begin
					cnt++;
				end else if (free_idx < 0) begin
					free_idx = i;
				end
			end
			compare("iq_enq_ready", 32'(cnt < IQ_ENTRIES), 32'(iq_enq_ready));
			if (iq_enq_valid && !iq_enq_ready) begin
				report_error("enqueue valid was driven while the queue was full");
			end

			// oldest candidate by acceptance order
			sel = -1;
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				if (slots[i].valid) begin
					wa = slots[i].rdy_a || woken(slots[i].a_pr);
					wb = slots[i].rdy_b || woken(slots[i].b_pr);
					if (wa && wb && (sel < 0 || slots[i].seq < slots[sel].seq)) begin
						sel = i;
					end
				end
			end
			exp_valid = issue_ready && (sel >= 0);
			if (exp_valid) begin
				exp_slot = slots[sel];
				exp_fwd_a = woken(exp_slot.a_pr) && !exp_slot.rdy_a;
				exp_fwd_b = woken(exp_slot.b_pr) && !exp_slot.rdy_b;
			end

			// wake and free
			for (int i = 0; i < IQ_ENTRIES; i++) begin
				if (slots[i].valid) begin
					slots[i].rdy_a = slots[i].rdy_a || woken(slots[i].a_pr);
					slots[i].rdy_b = slots[i].rdy_b || woken(slots[i].b_pr);
				end
			end
			if (exp_valid) begin
				slots[sel].valid = 1'b0;
			end

			// accept into a slot that was free before this edge
			if (iq_enq_valid && iq_enq_ready && free_idx >= 0) begin
				accepted_count++;
				slots[free_idx].valid = 1'b1;
				slots[free_idx].seq = next_seq;
				next_seq++;
				slots[free_idx].rdy_a = iq_enq_A_ready || iq_enq_A_unneeded_or_is_zero
					|| woken(iq_enq_A_PR);
				slots[free_idx].rdy_b = iq_enq_B_ready || iq_enq_B_unneeded_or_is_zero
					|| woken(iq_enq_B_PR);
				slots[free_idx].op = iq_enq_op;
				slots[free_idx].pc = iq_enq_PC;
				slots[free_idx].imm20 = iq_enq_imm20;
				slots[free_idx].a_pr = iq_enq_A_PR;
				slots[free_idx].b_pr = iq_enq_B_PR;
				slots[free_idx].a_un = iq_enq_A_unneeded_or_is_zero;
				slots[free_idx].b_un = iq_enq_B_unneeded_or_is_zero;
				slots[free_idx].dest = iq_enq_dest_PR;
				slots[free_idx].rob = iq_enq_ROB_index;
			end
		end
	end

endmodule

//--- verification/bru_iq_tb.sv
`timescale 1ns/1ps

module bru_iq_tb import bru_iq_pkg::*; ();

	localparam int IQ_ENTRIES = 8;
	localparam int N_OPS = 300;
	localparam int ENQ_TIMEOUT = 20000;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int PR_COUNT = 1 << LOG_PR_COUNT;
	localparam int UPPER_COUNT = 1 << (LOG_PR_COUNT - LOG_PRF_BANK_COUNT);

	logic CLK;
	logic nRST;

	logic iq_enq_valid;
	br_op_t iq_enq_op;
	pc_t iq_enq_PC;
	imm20_t iq_enq_imm20;
	pr_t iq_enq_A_PR;
	logic iq_enq_A_ready;
	logic iq_enq_A_unneeded_or_is_zero;
	pr_t iq_enq_B_PR;
	logic iq_enq_B_ready;
	logic iq_enq_B_unneeded_or_is_zero;
	pr_t iq_enq_dest_PR;
	rob_idx_t iq_enq_ROB_index;
	logic iq_enq_ready;

	logic [PRF_BANK_COUNT-1:0] WB_bus_valid_by_bank;
	upper_pr_t [PRF_BANK_COUNT-1:0] WB_bus_upper_PR_by_bank;

	logic issue_valid;
	br_op_t issue_op;
	pc_t issue_PC;
	imm20_t issue_imm20;
	logic issue_A_forward;
	logic issue_A_unneeded_or_is_zero;
	bank_t issue_A_bank;
	logic issue_B_forward;
	logic issue_B_unneeded_or_is_zero;
	bank_t issue_B_bank;
	pr_t issue_dest_PR;
	rob_idx_t issue_ROB_index;
	logic issue_ready;

	logic PRF_req_A_valid;
	pr_t PRF_req_A_PR;
	logic PRF_req_B_valid;
	pr_t PRF_req_B_PR;

	// sources still waiting for their writeback
	logic [PR_COUNT-1:0] pend;
	// destinations of ops in flight
	logic [PR_COUNT-1:0] dest_busy;
	int accepted;
	int issued;
	int tb_errors;

	bru_iq_top #(.IQ_ENTRIES(IQ_ENTRIES)) u_dut (.*);

	bru_iq_checker #(.IQ_ENTRIES(IQ_ENTRIES)) u_chk (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// --------------------
	// one cycle of random stimulus right after the rising edge

	task automatic drive_cycle(input bit allow_enq);
		logic [PRF_BANK_COUNT-1:0] wb_v;
		upper_pr_t [PRF_BANK_COUNT-1:0] wb_tag;
		int start;
		pr_t pr;
		pr_t a;
		pr_t b;
		pr_t dest;
		logic a_rdy;
		logic a_un;
		logic b_rdy;
		logic b_un;
		// what happened at this edge
		if (iq_enq_valid && iq_enq_ready) begin
			accepted++;
		end
		if (issue_valid) begin
			issued++;
			dest_busy[issue_dest_PR] = 1'b0;
		end

		// at most one pending register per bank
		wb_v = '0;
		wb_tag = '0;
		for (int bk = 0; bk < PRF_BANK_COUNT; bk++) begin
			start = $urandom % UPPER_COUNT;
			if (($urandom % 2) == 0) begin
				for (int k = 0; k < UPPER_COUNT; k++) begin
					pr = {upper_pr_t'((start + k) % UPPER_COUNT), bank_t'(bk)};
					if (!wb_v[bk] && pend[pr]) begin
						wb_v[bk] = 1'b1;
						wb_tag[bk] = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
						pend[pr] = 1'b0;
					end
				end
			end
		end
		WB_bus_valid_by_bank <= wb_v;
		WB_bus_upper_PR_by_bank <= wb_tag;
		issue_ready <= ($urandom % 4) != 0;

		// occupancy estimate never undercounts so ready must be high
		if (allow_enq && (accepted - issued) < IQ_ENTRIES && ($urandom % 4) != 0) begin
			a = pr_t'($urandom);
			b = pr_t'($urandom);
			a_rdy = ($urandom % 3) == 0;
			a_un = ($urandom % 6) == 0;
			b_rdy = ($urandom % 3) == 0;
			b_un = ($urandom % 6) == 0;
			if (!a_rdy && !a_un) begin
				pend[a] = 1'b1;
			end
			if (!b_rdy && !b_un) begin
				pend[b] = 1'b1;
			end
			dest = pr_t'($urandom);
			for (int t = 0; t < PR_COUNT && dest_busy[dest]; t++) begin
				dest = dest + pr_t'(1);
			end
			dest_busy[dest] = 1'b1;
			iq_enq_valid <= 1'b1;
			iq_enq_op <= br_op_t'($urandom);
			iq_enq_PC <= pc_t'($urandom);
			iq_enq_imm20 <= imm20_t'($urandom);
			iq_enq_A_PR <= a;
			iq_enq_A_ready <= a_rdy;
			iq_enq_A_unneeded_or_is_zero <= a_un;
			iq_enq_B_PR <= b;
			iq_enq_B_ready <= b_rdy;
			iq_enq_B_unneeded_or_is_zero <= b_un;
			iq_enq_dest_PR <= dest;
			iq_enq_ROB_index <= rob_idx_t'($urandom);
		end else begin
			iq_enq_valid <= 1'b0;
		end
	endtask

	task automatic report_result();
		int other;
		if (u_chk.accepted_count != accepted || u_chk.issued_count != accepted) begin
			tb_errors++;
			$display("error: checker counted %0d accepted and %0d issued ops, expected %0d each",
				u_chk.accepted_count, u_chk.issued_count, accepted);
		end
		other = tb_errors + u_chk.error_count;
		$display("errors: %0d mismatches, %0d other", u_chk.mismatch_count, other);
		if (u_chk.mismatch_count == 0 && other == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// --------------------
	// main sequence

	initial begin : stimulus
		int seed_ret;
		int cyc;
		nRST = 1'b0;
		iq_enq_valid = 1'b0;
		iq_enq_op = '0;
		iq_enq_PC = '0;
		iq_enq_imm20 = '0;
		iq_enq_A_PR = '0;
		iq_enq_A_ready = 1'b0;
		iq_enq_A_unneeded_or_is_zero = 1'b0;
		iq_enq_B_PR = '0;
		iq_enq_B_ready = 1'b0;
		iq_enq_B_unneeded_or_is_zero = 1'b0;
		iq_enq_dest_PR = '0;
		iq_enq_ROB_index = '0;
		WB_bus_valid_by_bank = '0;
		WB_bus_upper_PR_by_bank = '0;
		issue_ready = 1'b0;
		pend = '0;
		dest_busy = '0;
		accepted = 0;
		issued = 0;
		tb_errors = 0;
		seed_ret = $urandom(76240);

		repeat (4) @(posedge CLK);
		nRST <= 1'b1;

		// enqueue phase
		cyc = 0;
		while (accepted < N_OPS && cyc < ENQ_TIMEOUT) begin
			@(posedge CLK);
			drive_cycle(1'b1);
			cyc++;
		end
		if (accepted < N_OPS) begin
			tb_errors++;
			$display("error: timed out with only %0d of %0d ops enqueued", accepted, N_OPS);
		end

		// drain phase with wakeups and back-pressure still running
		cyc = 0;
		while ((issued < accepted || iq_enq_valid) && cyc < DRAIN_TIMEOUT) begin
			@(posedge CLK);
			drive_cycle(1'b0);
			cyc++;
		end
		if (issued < accepted) begin
			tb_errors++;
			$display("error: timed out with %0d ops still in the queue", accepted - issued);
		end

		repeat (2) @(posedge CLK);
		report_result();
	end

endmodule
